// ==== hdl/arcade_pkg.sv ====
package arcade_pkg;

    // Horizontal raster in pixels
    localparam int h_active     = 32;
    localparam int h_total      = 40;
    localparam int h_sync_start = 34;
    localparam int h_sync_len   = 3;

    // Vertical raster in lines
    localparam int v_active     = 16;
    localparam int v_total      = 20;
    localparam int v_sync_start = 17;
    localparam int v_sync_len   = 2;

    // One byte per visible pixel
    localparam int fb_words = h_active * v_active;

    // clk50 cycles per pixel
    localparam int pix_div = 2;

    typedef logic [5:0]  hpos_t;
    typedef logic [4:0]  vpos_t;
    typedef logic [8:0]  fb_addr_t;
    typedef logic [15:0] dl_addr_t;
    typedef logic [7:0]  pix_byte_t;
    typedef logic [7:0]  color_t;

    typedef struct packed {
        logic      en;
        fb_addr_t  addr;
        pix_byte_t data;
    } fb_wr_t;

    // Timing state for one pixel, syncs active low
    typedef struct packed {
        logic  cen;
        logic  hs;
        logic  vs;
        logic  de;
        hpos_t x;
        vpos_t y;
    } raster_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // Raster state in reset with syncs inactive
    localparam raster_t raster_idle = '{cen: 1'b0, hs: 1'b1, vs: 1'b1, de: 1'b0,
                                        x: '0, y: '0};

endpackage

// ==== hdl/rom_download.sv ====
`timescale 1ns/1ps

module rom_download import arcade_pkg::*; (
    input  logic      clk50,
    input  logic      arst_n,
    input  logic      dwnld_busy,
    input  logic      dwnld_we,
    input  dl_addr_t  dwnld_addr,
    input  pix_byte_t dwnld_data,
    output fb_wr_t    fb_wr,
    output logic      video_restart,
    output logic      hold
);

    logic      wr_en;
    fb_addr_t  wr_addr;
    pix_byte_t wr_data;
    logic      busy_q;

    // Strobe and end-of-download detection
    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            wr_en         <= 1'b0;
            busy_q        <= 1'b0;
            video_restart <= 1'b0;
        end else begin
            // Anything beyond the framebuffer is simply lost
            wr_en         <= dwnld_we && (dwnld_addr < dl_addr_t'(fb_words));
            busy_q        <= dwnld_busy;
            video_restart <= busy_q && !dwnld_busy;
        end
    end

    // Address and data only move with a strobe
    always_ff @(posedge clk50) begin
        if (dwnld_we) begin
            wr_addr <= fb_addr_t'(dwnld_addr);
            wr_data <= dwnld_data;
        end
    end

    assign fb_wr = '{en: wr_en, addr: wr_addr, data: wr_data};
    assign hold  = busy_q;

    // Loader only writes inside a download window
    a_we_in_busy: assert property (
        @(posedge clk50) disable iff (!arst_n)
        dwnld_we |-> dwnld_busy
    );

endmodule

// ==== hdl/video_timing.sv ====
`timescale 1ns/1ps

module video_timing import arcade_pkg::*; (
    input  logic    clk50,
    input  logic    arst_n,
    input  logic    video_restart,
    output raster_t raster
);

    typedef logic [$clog2(pix_div)-1:0] div_cnt_t;

    div_cnt_t div;
    hpos_t    hcnt;
    vpos_t    vcnt;
    logic     cen;
    logic     h_last;
    logic     v_last;
    logic     hs_zone;
    logic     vs_zone;

    assign cen    = (div == div_cnt_t'(pix_div - 1));
    assign h_last = (hcnt == hpos_t'(h_total - 1));
    assign v_last = (vcnt == vpos_t'(v_total - 1));

    // Pixel enable divider
    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            div <= '0;
        end else if (video_restart || cen) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;
        end
    end

    // Restart wins over the pixel enable
    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (video_restart) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (cen) begin
            if (h_last) begin
                hcnt <= '0;
                vcnt <= v_last ? '0 : vcnt + 1'b1;
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    assign hs_zone = (hcnt >= hpos_t'(h_sync_start)) &&
                     (hcnt <  hpos_t'(h_sync_start + h_sync_len));
    assign vs_zone = (vcnt >= vpos_t'(v_sync_start)) &&
                     (vcnt <  vpos_t'(v_sync_start + v_sync_len));

    // Decode straight from the counters
    always_comb begin
        raster.cen = cen;
        raster.hs  = !hs_zone;
        raster.vs  = !vs_zone;
        raster.de  = (hcnt < hpos_t'(h_active)) && (vcnt < vpos_t'(v_active));
        raster.x   = hcnt;
        raster.y   = vcnt;
    end

    a_count_range: assert property (
        @(posedge clk50) disable iff (!arst_n)
        (hcnt < hpos_t'(h_total)) && (vcnt < vpos_t'(v_total))
    );

endmodule

// ==== hdl/pixel_fetch.sv ====
`timescale 1ns/1ps

module pixel_fetch import arcade_pkg::*; (
    input  logic    clk50,
    input  logic    arst_n,
    input  fb_wr_t  fb_wr,
    input  raster_t raster_in,
    output raster_t raster_dly,
    output rgb_t    pixel
);

    pix_byte_t fb_mem [fb_words];
    fb_addr_t  rd_addr;
    pix_byte_t rd_byte;
    raster_t   raster_q;

    // RGB332 to 8 bits per channel by bit replication
    function automatic rgb_t expand_rgb332(input pix_byte_t p);
        rgb_t c;
        c.r = {p[7:5], p[7:5], p[7:6]};
        c.g = {p[4:2], p[4:2], p[4:3]};
        c.b = {4{p[1:0]}};
        return c;
    endfunction

    // Blanking positions wrap onto some address and are masked by de
    assign rd_addr = fb_addr_t'(raster_in.y * h_active + raster_in.x);

    // Download port and video port on one RAM
    always_ff @(posedge clk50) begin
        if (fb_wr.en) begin
            fb_mem[fb_wr.addr] <= fb_wr.data;
        end
        rd_byte <= fb_mem[rd_addr];
    end

    // Colour stage
    always_ff @(posedge clk50) begin
        pixel <= expand_rgb332(rd_byte);
    end

    // Timing follows the data through both stages
    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            raster_q   <= raster_idle;
            raster_dly <= raster_idle;
        end else begin
            raster_q   <= raster_in;
            raster_dly <= raster_q;
        end
    end

endmodule

// ==== hdl/video_out.sv ====
`timescale 1ns/1ps

module video_out import arcade_pkg::*; (
    input  logic        clk50,
    input  logic        arst_n,
    input  logic        hold,
    input  raster_t     raster,
    input  rgb_t        pixel,
    output logic        vga_ce,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_de,
    output color_t      vga_r,
    output color_t      vga_g,
    output color_t      vga_b,
    output logic [31:0] frame_cnt,
    output logic        led_user
);

    logic show;

    // Nothing visible while a download runs
    assign show = raster.de && !hold;

    always_ff @(posedge clk50 or negedge arst_n) begin
        if (!arst_n) begin
            vga_ce    <= 1'b0;
            vga_hs    <= 1'b1;
            vga_vs    <= 1'b1;
            vga_de    <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            frame_cnt <= '0;
            led_user  <= 1'b0;
        end else begin
            vga_ce   <= raster.cen;
            vga_hs   <= raster.hs;
            vga_vs   <= raster.vs;
            vga_de   <= show;
            vga_r    <= show ? pixel.r : '0;
            vga_g    <= show ? pixel.g : '0;
            vga_b    <= show ? pixel.b : '0;
            led_user <= hold;
            // Count lands with the vs falling edge on the pin
            if (vga_vs && !raster.vs) begin
                frame_cnt <= frame_cnt + 32'd1;
            end
        end
    end

    a_blank_black: assert property (
        @(posedge clk50) disable iff (!arst_n)
        !vga_de |-> (vga_r == '0) && (vga_g == '0) && (vga_b == '0)
    );

endmodule

// ==== hdl/arcade_core.sv ====
`timescale 1ns/1ps

module arcade_core import arcade_pkg::*; (
    input  logic        clk50,
    input  logic        arst_n,
    input  logic        dwnld_busy,
    input  logic        dwnld_we,
    input  dl_addr_t    dwnld_addr,
    input  pix_byte_t   dwnld_data,
    output logic        vga_ce,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_de,
    output color_t      vga_r,
    output color_t      vga_g,
    output color_t      vga_b,
    output logic [31:0] frame_cnt,
    output logic        led_user
);

    fb_wr_t  fb_wr;
    logic    video_restart;
    logic    hold;
    raster_t raster;
    raster_t raster_dly;
    rgb_t    pixel;

    rom_download u_rom_download (
        .clk50         ( clk50         ),
        .arst_n        ( arst_n        ),
        .dwnld_busy    ( dwnld_busy    ),
        .dwnld_we      ( dwnld_we      ),
        .dwnld_addr    ( dwnld_addr    ),
        .dwnld_data    ( dwnld_data    ),
        .fb_wr         ( fb_wr         ),
        .video_restart ( video_restart ),
        .hold          ( hold          )
    );

    video_timing u_video_timing (
        .clk50         ( clk50         ),
        .arst_n        ( arst_n        ),
        .video_restart ( video_restart ),
        .raster        ( raster        )
    );

    pixel_fetch u_pixel_fetch (
        .clk50      ( clk50      ),
        .arst_n     ( arst_n     ),
        .fb_wr      ( fb_wr      ),
        .raster_in  ( raster     ),
        .raster_dly ( raster_dly ),
        .pixel      ( pixel      )
    );

    video_out u_video_out (
        .clk50     ( clk50      ),
        .arst_n    ( arst_n     ),
        .hold      ( hold       ),
        .raster    ( raster_dly ),
        .pixel     ( pixel      ),
        .vga_ce    ( vga_ce     ),
        .vga_hs    ( vga_hs     ),
        .vga_vs    ( vga_vs     ),
        .vga_de    ( vga_de     ),
        .vga_r     ( vga_r      ),
        .vga_g     ( vga_g      ),
        .vga_b     ( vga_b      ),
        .frame_cnt ( frame_cnt  ),
        .led_user  ( led_user   )
    );

endmodule

// ==== sim/arcade_core_tb.sv ====
`timescale 1ns/1ps

module arcade_core_tb import arcade_pkg::*; ();

    localparam int clk_period = 100;
    localparam int frame_clks = h_total * v_total * pix_div;
    localparam int num_tests  = 4;
    localparam int oor_writes = 16;

    typedef enum int {fill_lcg, fill_const, fill_addr} fill_t;

    // One array per table column
    string     test_name  [num_tests] = '{"lcg_image", "const_fill", "addr_ramp", "lcg_oor"};
    fill_t     fill_mode  [num_tests] = '{fill_lcg, fill_const, fill_addr, fill_lcg};
    pix_byte_t fill_value [num_tests] = '{8'h00, 8'hb6, 8'h00, 8'h00};
    bit        add_oor    [num_tests] = '{1'b0, 1'b0, 1'b1, 1'b1};
    int        n_frames   [num_tests] = '{2, 1, 1, 2};

    logic        clk50;
    logic        arst_n;
    logic        dwnld_busy;
    logic        dwnld_we;
    dl_addr_t    dwnld_addr;
    pix_byte_t   dwnld_data;
    logic        vga_ce;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_de;
    color_t      vga_r;
    color_t      vga_g;
    color_t      vga_b;
    logic [31:0] frame_cnt;
    logic        led_user;

    pix_byte_t   model [fb_words];
    logic [31:0] lcg_state = 32'd94;
    int          errors = 0;
    int          exp_frames;
    logic        mon_vs;

    arcade_core u_arcade_core (
        .clk50      ( clk50      ),
        .arst_n     ( arst_n     ),
        .dwnld_busy ( dwnld_busy ),
        .dwnld_we   ( dwnld_we   ),
        .dwnld_addr ( dwnld_addr ),
        .dwnld_data ( dwnld_data ),
        .vga_ce     ( vga_ce     ),
        .vga_hs     ( vga_hs     ),
        .vga_vs     ( vga_vs     ),
        .vga_de     ( vga_de     ),
        .vga_r      ( vga_r      ),
        .vga_g      ( vga_g      ),
        .vga_b      ( vga_b      ),
        .frame_cnt  ( frame_cnt  ),
        .led_user   ( led_user   )
    );

    initial begin
        clk50 = 1'b0;
        forever #(clk_period / 2) clk50 = ~clk50;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Three bits repeated and cut to the top 8
    function automatic color_t rep3_to_8(input logic [2:0] v);
        logic [8:0] t;
        t = {3{v}};
        return t[8:1];
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_blanked();
        check_value("led_user", int'(led_user), 1);
        check_value("vga_de", int'(vga_de), 0);
        check_value("vga_r", int'(vga_r), 0);
        check_value("vga_g", int'(vga_g), 0);
        check_value("vga_b", int'(vga_b), 0);
    endtask

    task automatic write_byte(input dl_addr_t a, input pix_byte_t d);
        dwnld_we   = 1'b1;
        dwnld_addr = a;
        dwnld_data = d;
        @(negedge clk50);
        check_blanked();
    endtask

    task automatic download_image(input int row);
        int        i;
        int        k;
        int        idx;
        pix_byte_t b;
        dl_addr_t  a;
        dwnld_busy = 1'b1;
        // Two cycles until hold reaches the pins
        repeat (2) @(negedge clk50);
        for (i = 0; i < fb_words; i++) begin
            case (fill_mode[row])
                fill_lcg: begin
                    lcg_state = lcg_step(lcg_state);
                    b = lcg_state[23:16];
                end
                fill_const: b = fill_value[row];
                default:    b = pix_byte_t'(i);
            endcase
            model[i] = b;
            write_byte(dl_addr_t'(i), b);
        end
        // Inverted data so a wrapped write would show up
        if (add_oor[row]) begin
            for (k = 0; k < oor_writes; k++) begin
                a = dl_addr_t'(fb_words + k * 4093);
                idx = int'(a) % fb_words;
                write_byte(a, ~model[idx]);
            end
        end
        dwnld_we = 1'b0;
    endtask

    task automatic release_video();
        // Let go during vertical sync so the restart lands in blanking
        while (vga_vs) begin
            @(negedge clk50);
            check_blanked();
        end
        dwnld_busy = 1'b0;
        repeat (2) @(negedge clk50);
        check_value("led_user", int'(led_user), 0);
    endtask

    task automatic run_frames(input int frames);
        int        vs_falls;
        int        x;
        int        y;
        int        hs_run;
        int        vs_run;
        int        ce_gap;
        bit        hs_seen;
        bit        vs_seen;
        bit        done;
        logic      prev_hs;
        logic      prev_vs;
        logic      prev_de;
        pix_byte_t p;
        vs_falls = 0;
        x = 0;
        y = 0;
        hs_run = 0;
        vs_run = 0;
        ce_gap = 0;
        hs_seen = 1'b0;
        vs_seen = 1'b0;
        done = 1'b0;
        prev_hs = vga_hs;
        prev_vs = vga_vs;
        prev_de = vga_de;
        while (!done) begin
            @(negedge clk50);
            ce_gap++;
            if (vga_ce) begin
                // Pixel enable spacing once the raster runs freely
                if (vs_seen) begin
                    check_value("vga_ce period", ce_gap, pix_div);
                end
                ce_gap = 0;
                if (!vga_hs) begin
                    if (prev_hs) begin
                        hs_seen = 1'b1;
                        hs_run = 0;
                    end
                    hs_run++;
                end else if (!prev_hs && hs_seen) begin
                    check_value("vga_hs low pixels", hs_run, h_sync_len);
                end
                // A frame ends at each falling edge of vs
                if (!vga_vs) begin
                    if (prev_vs) begin
                        check_value("vga_de lines per frame", y, v_active);
                        vs_seen = 1'b1;
                        vs_run = 0;
                        y = 0;
                        vs_falls++;
                    end
                    vs_run++;
                end else if (!prev_vs && vs_seen) begin
                    check_value("vga_vs low pixels", vs_run, v_sync_len * h_total);
                    done = (vs_falls >= frames);
                end
                if (vga_de) begin
                    if (!prev_de) begin
                        x = 0;
                    end
                    assert (x < h_active && y < v_active) else begin
                        $display("Error at %0t ns: pixel outside the active area, x %0d y %0d",
                                 $time, x, y);
                        errors++;
                    end
                    p = model[(y * h_active + x) % fb_words];
                    check_value("vga_r", int'(vga_r), int'(rep3_to_8(p[7:5])));
                    check_value("vga_g", int'(vga_g), int'(rep3_to_8(p[4:2])));
                    // Two bits times 0x55 repeat them four times
                    check_value("vga_b", int'(vga_b), int'(p[1:0]) * 85);
                    x++;
                end else begin
                    check_value("vga_r", int'(vga_r), 0);
                    check_value("vga_g", int'(vga_g), 0);
                    check_value("vga_b", int'(vga_b), 0);
                    if (prev_de) begin
                        check_value("vga_de pixels per line", x, h_active);
                        y++;
                    end
                end
                prev_hs = vga_hs;
                prev_vs = vga_vs;
                prev_de = vga_de;
            end
        end
    endtask

    // Frame count from every falling edge of vs since reset
    always @(negedge clk50) begin
        if (!arst_n) begin
            exp_frames = 0;
            mon_vs = 1'b1;
        end else begin
            if (mon_vs && !vga_vs) begin
                exp_frames++;
            end
            check_value("frame_cnt", int'(frame_cnt), exp_frames);
            mon_vs = vga_vs;
        end
    end

    initial begin : watchdog
        longint limit;
        int     t;
        limit = 20;
        for (t = 0; t < num_tests; t++) begin
            limit += 2 * n_frames[t] * frame_clks + fb_words + oor_writes + frame_clks;
        end
        #(limit * clk_period);
        $display("Watchdog expired after %0d clock cycles, the tests did not finish", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        int row;
        int errs_before;
        int failed_tests;
        arst_n       = 1'b0;
        dwnld_busy   = 1'b0;
        dwnld_we     = 1'b0;
        dwnld_addr   = '0;
        dwnld_data   = '0;
        failed_tests = 0;
        repeat (5) @(negedge clk50);
        arst_n = 1'b1;
        for (row = 0; row < num_tests; row++) begin
            errs_before = errors;
            download_image(row);
            release_video();
            run_frames(n_frames[row]);
            if (errors == errs_before) begin
                $display("[TEST] %s: ok, %0d frame(s)", test_name[row], n_frames[row]);
            end else begin
                failed_tests++;
                $display("[TEST] %s: %0d error(s)", test_name[row], errors - errs_before);
            end
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== arcade_core.f ====
hdl/arcade_pkg.sv
hdl/rom_download.sv
hdl/video_timing.sv
hdl/pixel_fetch.sv
hdl/video_out.sv
hdl/arcade_core.sv
sim/arcade_core_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := arcade_core_tb
FILELIST   := arcade_core.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
